//--- design/bnn_defs.svh
`ifndef BNN_DEFS_SVH
`define BNN_DEFS_SVH

// side of the largest kernel square
`define BNN_K_MAX 5

// cells in the full window, row-major
`define BNN_GRID_BITS 25

// enough for a count of 0 to 25
`define BNN_COUNT_W 5

`endif

//--- design/bnn_pkg.sv
`include "bnn_defs.svh"

package bnn_pkg;

    // opcodes 2 and 3 decode but produce a zero result
    typedef enum logic [1:0] {
        OP_CONV     = 2'd0,
        OP_POOL     = 2'd1,
        OP_LINEAR   = 2'd2,
        OP_RESERVED = 2'd3
    } bnn_op_e;

    // one bit per row or column
    typedef logic [`BNN_K_MAX-1:0] lane_t;

    // cell (r, c) at index 5r+c, column 4 is the entry side
    typedef logic [`BNN_GRID_BITS-1:0] grid_t;

    typedef logic [`BNN_COUNT_W-1:0] count_t;

    // kernel side k, 1 to 5
    typedef logic [$clog2(`BNN_K_MAX + 1)-1:0] dim_t;

endpackage

//--- design/bnn_cfg_if.sv
`timescale 1ns/10ps

interface bnn_cfg_if import bnn_pkg::*; ();

    bnn_op_e op;
    lane_t   row_mask;
    lane_t   col_mask;
    dim_t    kernel_dim;
    logic    shift_en;
    logic    weight_wr;
    logic    pixel_gate;

    modport decode (
        output op,
        output row_mask,
        output col_mask,
        output kernel_dim,
        output shift_en,
        output weight_wr,
        output pixel_gate
    );

    modport execute (
        input row_mask,
        input col_mask,
        input kernel_dim,
        input shift_en,
        input weight_wr,
        input pixel_gate
    );

    // result only needs the opcode
    modport result (
        input op
    );

endinterface

//--- design/bnn_decode.sv
`timescale 1ns/10ps
`include "bnn_defs.svh"

module bnn_decode import bnn_pkg::*; (
    input  logic [1:0]       operation,
    input  lane_t            kernel_size,
    input  logic             load_ifmaps,
    input  logic             load_weight,
    input  logic             enable,
    bnn_cfg_if.decode        cfg
);

    bnn_op_e op_dec;
    dim_t    k;
    lane_t   row_mask_d;
    lane_t   col_mask_d;

    assign op_dec = bnn_op_e'(operation);

    // one-hot size to kernel side, zero if not one-hot
    always_comb begin
        k = '0;
        for (int i = 0; i < `BNN_K_MAX; i++) begin
            if (kernel_size == lane_t'(1 << i)) begin
                k = dim_t'(i + 1);
            end
        end
    end

    // active square sits in the top-right corner
    always_comb begin
        for (int i = 0; i < `BNN_K_MAX; i++) begin
            row_mask_d[i] = (i < k);
            col_mask_d[i] = (i >= `BNN_K_MAX - k);
        end
    end

    assign cfg.op         = op_dec;
    assign cfg.kernel_dim = k;
    assign cfg.row_mask   = row_mask_d;
    assign cfg.col_mask   = col_mask_d;
    assign cfg.shift_en   = load_ifmaps;
    assign cfg.pixel_gate = enable;

    // weights only change under convolution
    assign cfg.weight_wr  = load_weight && (op_dec == OP_CONV);

    // both register groups rely on a single size bit during a load
    always_comb begin
        if (load_ifmaps || load_weight) begin
            assert ($onehot(kernel_size))
            else $error("bnn_decode: kernel_size %b not one-hot during load", kernel_size);
        end
    end

endmodule

//--- design/ifmap_window.sv
`timescale 1ns/10ps
`include "bnn_defs.svh"

module ifmap_window import bnn_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    bnn_cfg_if.execute cfg,
    input  lane_t      ifmap_rows,
    output grid_t      pixels
);

    localparam int K = `BNN_K_MAX;

    grid_t square;
    grid_t shifted;
    grid_t dim_square;

    // cells move toward column 0, new column enters at column K-1
    always_comb begin
        for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K; c++) begin
                square[K*r+c] = cfg.row_mask[r] & cfg.col_mask[c];
                if (c == K - 1) begin
                    shifted[K*r+c] = ifmap_rows[r] & cfg.pixel_gate & cfg.row_mask[r];
                end else begin
                    shifted[K*r+c] = pixels[K*r+c+1];
                end
            end
        end
    end

    // outside cells clear on the same edge as the shift
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixels <= '0;
        end else if (cfg.shift_en) begin
            pixels <= shifted & square;
        end
    end

    // square from the kernel side alone, independent of the decoded masks
    always_comb begin
        for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K; c++) begin
                dim_square[K*r+c] = (r < int'(cfg.kernel_dim)) &&
                                    (c >= K - int'(cfg.kernel_dim));
            end
        end
    end

    // square as it was at the shift, since the size may move afterwards
    assert property (@(posedge clk) disable iff (!rst_n)
        cfg.shift_en |=> (pixels & ~$past(dim_square)) == '0)
    else $error("ifmap_window: pixel left outside the kernel square");

endmodule

//--- design/weight_bank.sv
`timescale 1ns/10ps
`include "bnn_defs.svh"

module weight_bank import bnn_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    bnn_cfg_if.execute cfg,
    input  grid_t      weight_in,
    output grid_t      weights
);

    localparam int K = `BNN_K_MAX;

    grid_t written;

    // square cells take weight_in bits in row-major order from bit 0,
    // everything else reads as 1 so its XNOR with a zero pixel is 0
    always_comb begin
        logic [$clog2(`BNN_GRID_BITS)-1:0] idx;
        idx     = '0;
        written = '1;
        for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K; c++) begin
                if (cfg.row_mask[r] && cfg.col_mask[c]) begin
                    written[K*r+c] = weight_in[idx] | ~cfg.pixel_gate;
                    idx = idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weights <= '1;
        end else if (cfg.weight_wr) begin
            weights <= written;
        end
    end

endmodule

//--- design/bnn_execute.sv
`timescale 1ns/10ps

module bnn_execute import bnn_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    bnn_cfg_if.execute cfg,
    input  lane_t      ifmap_rows,
    input  grid_t      weight_in,
    output grid_t      match_map,
    output grid_t      pixel_map
);

    grid_t pixels;
    grid_t weights;

    ifmap_window u_window (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .ifmap_rows (ifmap_rows),
        .pixels     (pixels)
    );

    weight_bank u_weights (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .weight_in (weight_in),
        .weights   (weights)
    );

    assign match_map = pixels ~^ weights;
    assign pixel_map = pixels;

    // a match on a zero pixel needs a zero weight, and after a write
    // zero weights exist only inside the k x k square
    assert property (@(posedge clk) disable iff (!rst_n)
        cfg.weight_wr |=> $countones(match_map & ~pixel_map) <=
            $past(cfg.kernel_dim) * $past(cfg.kernel_dim))
    else $error("bnn_execute: match count beyond kernel square");

endmodule

//--- design/bnn_result.sv
`timescale 1ns/10ps
`include "bnn_defs.svh"

module bnn_result import bnn_pkg::*; (
    bnn_cfg_if.result cfg,
    input  grid_t     match_map,
    input  grid_t     pixel_map,
    output count_t    mac_out
);

    count_t match_count;
    logic   pool_or;

    // popcount of the XNOR map
    always_comb begin
        match_count = '0;
        for (int i = 0; i < `BNN_GRID_BITS; i++) begin
            match_count = match_count + count_t'(match_map[i]);
        end
    end

    // max pooling over single-bit pixels
    assign pool_or = |pixel_map;

    always_comb begin
        case (cfg.op)
            OP_CONV: mac_out = match_count;
            OP_POOL: mac_out = count_t'(pool_or);
            default: mac_out = '0;
        endcase
    end

endmodule

//--- design/bnn_pe.sv
`timescale 1ns/10ps

module bnn_pe import bnn_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enable,
    input  logic       load_ifmaps,
    input  logic       load_weight,
    input  logic [1:0] operation,
    input  lane_t      kernel_size,
    input  lane_t      ifmap_rows,
    input  grid_t      weight_in,
    output count_t     mac_out
);

    grid_t match_map;
    grid_t pixel_map;

    bnn_cfg_if cfg_if ();

    bnn_decode u_decode (
        .operation   (operation),
        .kernel_size (kernel_size),
        .load_ifmaps (load_ifmaps),
        .load_weight (load_weight),
        .enable      (enable),
        .cfg         (cfg_if.decode)
    );

    bnn_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg_if.execute),
        .ifmap_rows (ifmap_rows),
        .weight_in  (weight_in),
        .match_map  (match_map),
        .pixel_map  (pixel_map)
    );

    bnn_result u_result (
        .cfg       (cfg_if.result),
        .match_map (match_map),
        .pixel_map (pixel_map),
        .mac_out   (mac_out)
    );

endmodule

//--- verification/bnn_pe_tb.sv
`timescale 1ns/10ps

module bnn_pe_tb;

    localparam string STIM_FILE      = "verification/bnn_stim.txt";
    localparam int    RESET_CYCLES   = 5;
    localparam int    TIMEOUT_MARGIN = 20;

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic        load_ifmaps;
    logic        load_weight;
    logic [1:0]  operation;
    logic [4:0]  kernel_size;
    logic [4:0]  ifmap_rows;
    logic [24:0] weight_in;
    logic [4:0]  mac_out;

    // one entry per vector line
    logic [4:0]  vec_kernel[$];
    logic [1:0]  vec_op[$];
    logic        vec_enable[$];
    logic        vec_shift[$];
    logic        vec_wload[$];
    logic [4:0]  vec_rows[$];
    logic [24:0] vec_weight[$];
    logic [4:0]  vec_expect[$];

    int error_count;
    int cycle_limit;
    int cycle_count = 0;
    bit file_ok;

    bnn_pe DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .load_ifmaps (load_ifmaps),
        .load_weight (load_weight),
        .operation   (operation),
        .kernel_size (kernel_size),
        .ifmap_rows  (ifmap_rows),
        .weight_in   (weight_in),
        .mac_out     (mac_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // limit covers reset plus one cycle per vector
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic read_vectors(output bit ok);
        int          fd;
        int          n;
        string       line;
        byte         first_char;
        logic [31:0] f_kernel;
        logic [31:0] f_op;
        logic [31:0] f_enable;
        logic [31:0] f_shift;
        logic [31:0] f_wload;
        logic [31:0] f_rows;
        logic [31:0] f_weight;
        logic [31:0] f_expect;
        ok = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", STIM_FILE);
        end else begin
            while ($feof(fd) == 0) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1) begin
                    first_char = line.getc(0);
                    // '#' lines are comments
                    if (first_char != "#") begin
                        n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                    f_kernel, f_op, f_enable, f_shift,
                                    f_wload, f_rows, f_weight, f_expect);
                        if (n == 8) begin
                            vec_kernel.push_back(f_kernel[4:0]);
                            vec_op.push_back(f_op[1:0]);
                            vec_enable.push_back(f_enable[0]);
                            vec_shift.push_back(f_shift[0]);
                            vec_wload.push_back(f_wload[0]);
                            vec_rows.push_back(f_rows[4:0]);
                            vec_weight.push_back(f_weight[24:0]);
                            vec_expect.push_back(f_expect[4:0]);
                        end
                    end
                end
            end
            $fclose(fd);
            if (vec_expect.size() == 0) begin
                $display("stimulus file %s holds no vectors", STIM_FILE);
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    // size first, so the decode never sees a load with a stale size
    task automatic apply_vector(input int i);
        kernel_size = vec_kernel[i];
        operation   = vec_op[i];
        enable      = vec_enable[i];
        ifmap_rows  = vec_rows[i];
        weight_in   = vec_weight[i];
        load_ifmaps = vec_shift[i];
        load_weight = vec_wload[i];
    endtask

    task automatic check_output(input int i);
        assert (mac_out === vec_expect[i])
        else begin
            $display("Mismatch: mac_out at vector %0d expected %h actual %h",
                     i, vec_expect[i], mac_out);
            error_count++;
        end
    endtask

    initial begin
        error_count = 0;
        cycle_limit = TIMEOUT_MARGIN;
        rst_n       = 1'b0;
        enable      = 1'b0;
        load_ifmaps = 1'b0;
        load_weight = 1'b0;
        operation   = 2'd0;
        kernel_size = 5'h10;
        ifmap_rows  = '0;
        weight_in   = '0;
        read_vectors(file_ok);
        if (!file_ok) begin
            $display("Test failed");
            $finish;
        end else begin
            cycle_limit = vec_expect.size() + TIMEOUT_MARGIN;
            repeat (RESET_CYCLES) @(posedge clk);
            #1;
            rst_n = 1'b1;
            // output is checked just before the edge that samples the vector
            for (int i = 0; i < vec_expect.size(); i++) begin
                @(posedge clk);
                #1;
                apply_vector(i);
                #8;
                check_output(i);
            end
            $display("%0d vectors checked, %0d errors", vec_expect.size(), error_count);
            if (error_count == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

//--- bnn_pe.f
+incdir+design
design/bnn_pkg.sv
design/bnn_cfg_if.sv
design/bnn_decode.sv
design/ifmap_window.sv
design/weight_bank.sv
design/bnn_execute.sv
design/bnn_result.sv
design/bnn_pe.sv
verification/bnn_pe_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f bnn_pe.f \
		--top-module bnn_pe_tb -o bnn_pe_sim
	@out="$$(./obj_dir/bnn_pe_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

//--- verification/bnn_stim.txt
# columns: kernel_size operation enable load_ifmaps load_weight ifmap_rows weight_in mac_out
# mac_out is sampled before the edge that takes this line's loads
# after reset, every opcode gives 0
10 0 1 0 0 00 0000000 00
10 1 1 0 0 00 0000000 00
10 2 1 0 0 00 0000000 00
10 3 1 0 0 00 0000000 00
# kernel 5, five shifts, weights still all ones so count equals pixels
10 0 1 1 0 15 0000000 00
10 0 1 1 0 0a 0000000 03
10 0 1 1 0 1f 0000000 05
10 0 1 1 0 00 0000000 0a
10 0 1 1 0 03 0000000 0a
10 0 1 0 0 00 0000000 0c
# weight load, pixels 05316d5 against weights 0a5f00f give 9 matches
10 0 1 0 1 00 0a5f00f 0c
10 0 1 0 0 00 0000000 09
10 1 1 0 0 00 0000000 01
10 2 1 0 0 00 0000000 00
10 3 1 0 0 00 0000000 00
# weight load under pooling is ignored
10 1 1 0 1 00 1ffffff 01
10 0 1 0 0 00 0000000 09
# kernel 3, rows 3 and 4 masked, columns 0 and 1 cleared
04 0 1 1 0 1d 0000000 09
04 0 1 1 0 1a 0000000 0d
04 0 1 1 0 19 0000000 0e
# only weight_in bits 0 to 8 land in the square
04 0 1 0 1 00 000005a 0d
04 0 1 0 0 00 0000000 05
04 0 1 0 1 00 1fffe55 05
04 0 1 0 0 00 0000000 09
04 1 1 0 0 00 0000000 01
# enable low, shifts enter zeros and the weight load writes ones
04 0 0 1 0 07 0000000 09
04 0 0 0 1 00 0000000 03
04 0 1 0 0 00 0000000 02
04 0 0 1 0 07 0000000 02
04 0 0 1 0 07 0000000 01
04 0 1 0 0 00 0000000 00
04 1 1 0 0 00 0000000 00
# pooling, row 4 is outside the square and row 2 is inside
04 1 1 1 0 10 0000000 00
04 1 1 1 0 04 0000000 00
04 1 1 0 0 00 0000000 01
04 2 1 0 0 00 0000000 00
04 3 1 0 0 00 0000000 00
04 0 1 0 0 00 0000000 01
# weight load under the linear opcode is ignored too
04 2 1 0 1 00 0000000 00
04 0 1 0 0 00 0000000 01
